//--- build.f
commonPkg.sv
pipesPkg.sv
alu.sv
branchUnit.sv
trapUnit.sv
execute.sv
exMemReg.sv
exStage.sv
exChecker.sv
exStage_asserts.sv
tbExStage.sv

//--- Bender.yml
package:
  name: exStage

sources:
  - commonPkg.sv
  - pipesPkg.sv
  - alu.sv
  - branchUnit.sv
  - trapUnit.sv
  - execute.sv
  - exMemReg.sv
  - exStage.sv
  - target: test
    files:
      - exChecker.sv
      - exStage_asserts.sv
      - tbExStage.sv

//--- tbExStage.sv
`timescale 1ns/1ps

module tbExStage;
    import commonPkg::*;
    import pipesPkg::*;

    localparam int numCycles   = 2000;
    localparam int resetCycles = 10;
    localparam int waitLimit   = 50;

    logic         clk;
    logic         arstN;
    decodeData_t  dataD;
    fwdData_t     fwdA;
    fwdData_t     fwdB;
    logic         stall;
    logic         flush;
    executeData_t dataM;
    u1            branchEnable;
    word_t        branchTarget;
    int           checkCount;
    int           errorCount;
    int           timeouts;
    word_t        rngState;

    exStage dut_i (
        .clk(clk),
        .arstN(arstN),
        .dataD(dataD),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .stall(stall),
        .flush(flush),
        .dataM(dataM),
        .branchEnable(branchEnable),
        .branchTarget(branchTarget)
    );

    exChecker checker_i (
        .clk(clk),
        .arstN(arstN),
        .dataD(dataD),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .stall(stall),
        .flush(flush),
        .dataM(dataM),
        .branchEnable(branchEnable),
        .branchTarget(branchTarget),
        .checkCount(checkCount),
        .errorCount(errorCount)
    );

    always #5 clk = ~clk;

    function automatic word_t nextRandom();
        word_t x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 7;
        x ^= x << 17;
        rngState = x;
        return x;
    endfunction

    function automatic decodeData_t randomDecode();
        decodeData_t d;
        word_t       r;
        r          = nextRandom();
        d.valid    = r[2:0] != 3'd0;
        d.rawInstr = r[63:32];
        d.csrAddr  = r[16:5];
        d.ra1      = r[21:17];
        d.ra2      = r[26:22];
        d.dst      = r[31:27];
        d.pc       = nextRandom();
        d.srca     = nextRandom();
        d.srcb     = (r[4:3] == 2'd0) ? d.srca : nextRandom(); // equal compare now and then
        d.imm      = nextRandom();
        d.csrData  = nextRandom();
        r          = nextRandom();
        d.ctl.aluFunc    = aluFunc_t'(r[7:0] % 11);
        d.ctl.branchFunc = branchFunc_t'(r[10:8]);
        d.ctl.pcSrc      = r[11];
        d.ctl.immSrc     = r[12];
        d.ctl.aluExt     = r[13];
        d.ctl.csrSrc     = r[16:14] == 3'd0;
        d.ctl.jal        = r[19:17] == 3'd0;
        d.ctl.jalr       = r[22:20] == 3'd0;
        d.ctl.exception  = r[25:23] == 3'd0;
        d.ctl.mret       = !d.ctl.exception && r[28:26] == 3'd0;
        d.ctl.memRead    = r[30:29] == 2'd1;
        d.ctl.memWrite   = r[30:29] == 2'd2;
        d.ctl.memSize    = memSize_t'(r[32:31]);
        d.privilegeMode  = r[34:33];
        d.extraMstatus.raw = nextRandom();
        return d;
    endfunction

    function automatic fwdData_t randomFwd();
        fwdData_t f;
        word_t    r;
        r        = nextRandom();
        f.enable = r[0];
        f.data   = nextRandom();
        return f;
    endfunction

    initial begin
        word_t r;
        int    waited;
        rngState = 64'd27065;
        timeouts = 0;
        clk      = 1'b0;
        arstN    = 1'b0;
        dataD    = '0;
        fwdA     = '0;
        fwdB     = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        waited = 0;
        @(negedge clk);
        while ((dataM.valid !== 1'b0 || dataM.ctl !== '0) && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (dataM.valid !== 1'b0 || dataM.ctl !== '0) begin
            $display("timeout waiting for an empty pipeline register after reset");
            timeouts++;
        end else begin
            for (int i = 0; i < numCycles; i++) begin
                @(posedge clk);
                r = nextRandom();
                dataD <= randomDecode();
                fwdA  <= randomFwd();
                fwdB  <= randomFwd();
                stall <= r[2:0] == 3'd0;
                flush <= r[5:3] == 3'd0;
            end
            @(posedge clk);
            dataD <= '0;   // idle bubbles to drain
            fwdA  <= '0;
            fwdB  <= '0;
            stall <= 1'b0;
            flush <= 1'b0;
            waited = 0;
            @(negedge clk);
            while (dataM.valid !== 1'b0 && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (dataM.valid !== 1'b0) begin
                $display("timeout waiting for the pipeline register to drain");
                timeouts++;
            end
            @(posedge clk);
        end
        $display("checks %0d errors %0d assertion failures %0d timeouts %0d",
                 checkCount, errorCount, dut_i.asserts_i.failures, timeouts);
        if (errorCount == 0 && timeouts == 0 && dut_i.asserts_i.failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- exStage_asserts.sv
`timescale 1ns/1ps

module exStageAsserts (
    input logic                   clk,
    input logic                   arstN,
    input logic                   stall,
    input logic                   flush,
    input pipesPkg::executeData_t dataM,
    input logic                   branchEnable,
    input commonPkg::word_t       branchTarget
);
    import pipesPkg::*;

    int failures = 0;

    emptyAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !dataM.valid)
        else begin
            $error("dataM valid right after reset");
            failures++;
        end

    flushEmpties: assert property (@(posedge clk) disable iff (!arstN)
        flush |=> !dataM.valid && dataM.ctl == '0)
        else begin
            $error("dataM not empty after flush");
            failures++;
        end

    stallHolds: assert property (@(posedge clk) disable iff (!arstN)
        stall && !flush |=> $stable(dataM))
        else begin
            $error("dataM changed during stall");
            failures++;
        end

    targetMasked: assert property (@(posedge clk) disable iff (!arstN)
        !branchEnable |-> branchTarget == '0)
        else begin
            $error("branchTarget nonzero without redirect");
            failures++;
        end

endmodule

bind exStage exStageAsserts asserts_i (
    .clk(clk),
    .arstN(arstN),
    .stall(stall),
    .flush(flush),
    .dataM(dataM),
    .branchEnable(branchEnable),
    .branchTarget(branchTarget)
);

//--- exChecker.sv
`timescale 1ns/1ps

module exChecker (
    input  logic                   clk,
    input  logic                   arstN,
    input  pipesPkg::decodeData_t  dataD,
    input  pipesPkg::fwdData_t     fwdA,
    input  pipesPkg::fwdData_t     fwdB,
    input  logic                   stall,
    input  logic                   flush,
    input  pipesPkg::executeData_t dataM,
    input  logic                   branchEnable,
    input  commonPkg::word_t       branchTarget,
    output int                     checkCount,
    output int                     errorCount
);
    import commonPkg::*;
    import pipesPkg::*;

    typedef struct packed {
        executeData_t entry;
        u1            branchEnable;
        word_t        branchTarget;
    } refOut_t;

    refOut_t      predicted;
    executeData_t expM;    // one-deep model of exMemReg

    function automatic refOut_t refModel(decodeData_t d, fwdData_t fa, fwdData_t fb);
        refOut_t    o;
        control_t   c;
        word_t      ra;
        word_t      rb;
        word_t      a;
        word_t      b;
        word_t      r;
        word_t      nextPc;
        word_t      ms;
        logic [5:0] sa;
        u2          priv;
        u1          taken;
        c  = d.ctl;
        ra = fa.enable ? fa.data : d.srca;
        rb = fb.enable ? fb.data : d.srcb;
        a  = c.pcSrc ? d.pc : (c.csrSrc ? d.csrData : ra);
        b  = c.immSrc ? d.imm : rb;
        sa = c.aluExt ? {1'b0, b[4:0]} : b[5:0];
        case (c.aluFunc)
            aluAdd:  r = a + b;
            aluSub:  r = a - b;
            aluAnd:  r = a & b;
            aluOr:   r = a | b;
            aluXor:  r = a ^ b;
            aluSll:  r = a << sa;    // low half is all that counts for word ops
            aluSrl:  r = (c.aluExt ? {32'b0, a[31:0]} : a) >> sa;
            aluSra:  r = $signed(c.aluExt ? {{32{a[31]}}, a[31:0]} : a) >>> sa;
            aluSlt:  r = {63'b0, $signed(a) < $signed(b)};
            aluSltu: r = {63'b0, a < b};
            default: r = b;
        endcase
        if (c.aluExt) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        case (c.branchFunc)
            brEq:     taken = ra == rb;
            brNe:     taken = ra != rb;
            brLt:     taken = $signed(ra) < $signed(rb);
            brGe:     taken = $signed(ra) >= $signed(rb);
            brLtu:    taken = ra < rb;
            brGeu:    taken = ra >= rb;
            brAlways: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
        o.branchEnable = taken | c.jal | c.jalr | c.mret | c.exception | c.csrSrc;
        if (c.exception || c.mret) begin
            nextPc = d.csrData;
        end else if (c.csrSrc) begin
            nextPc = d.pc + 64'd4;
        end else if (c.jalr) begin
            nextPc = r & ~64'd1;
        end else begin
            nextPc = r;
        end
        o.branchTarget = o.branchEnable ? nextPc : '0;
        ms   = d.extraMstatus.raw;   // mie 3, mpie 7, mpp 12:11, xs 16:15
        priv = d.privilegeMode;
        if (c.exception) begin
            ms[12:11] = priv;
            ms[7]     = ms[3];
            ms[3]     = 1'b0;
            priv      = 2'd3;
        end else if (c.mret) begin
            ms[3]     = ms[7];
            ms[7]     = 1'b1;
            ms[12:11] = 2'd0;
            ms[16:15] = 2'd0;
            priv      = 2'd0;
        end
        o.entry                  = '0;
        o.entry.valid            = d.valid;
        o.entry.pc               = d.pc;
        o.entry.rawInstr         = d.valid ? d.rawInstr : '0;
        o.entry.aluOut           = (c.jal || c.jalr) ? d.pc + 64'd4 : r;
        o.entry.memWd            = rb;
        o.entry.csrData          = d.csrData;
        o.entry.csrAddr          = d.csrAddr;
        o.entry.ra1              = d.ra1;
        o.entry.ra2              = d.ra2;
        o.entry.dst              = d.dst;
        o.entry.ctl              = d.valid ? c : '0;
        o.entry.newMstatus.raw   = ms;
        o.entry.privilegeMode    = d.privilegeMode;
        o.entry.newPrivilegeMode = priv;
        if (c.memRead || c.memWrite) begin
            case (c.memSize)
                size2:   o.entry.misaligned = r[0];
                size4:   o.entry.misaligned = |r[1:0];
                size8:   o.entry.misaligned = |r[2:0];
                default: o.entry.misaligned = 1'b0;
            endcase
        end
        o.entry.mcause = c.memWrite ? 64'd6 : (c.memRead ? 64'd4 : 64'd0);
        return o;
    endfunction

    task automatic checkValue(string name, logic [$bits(executeData_t)-1:0] expVal,
                              logic [$bits(executeData_t)-1:0] gotVal);
        checkCount++;
        if (gotVal !== expVal) begin
            errorCount++;
            $display("[FAIL] %s expected %0h actual %0h", name, expVal, gotVal);
        end
    endtask

    initial begin
        checkCount = 0;
        errorCount = 0;
    end

    always_comb predicted = refModel(dataD, fwdA, fwdB);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expM <= '0;
        end else if (flush) begin
            expM <= '0;
        end else if (!stall) begin
            expM <= predicted.entry;
        end
    end

    // mid-cycle, inputs and flops have settled
    always @(negedge clk) begin
        if (arstN) begin
            checkValue("branchEnable", predicted.branchEnable, branchEnable);
            checkValue("branchTarget", predicted.branchTarget, branchTarget);
            checkValue("dataM.valid", expM.valid, dataM.valid);
            checkValue("dataM.aluOut", expM.aluOut, dataM.aluOut);
            checkValue("dataM.memWd", expM.memWd, dataM.memWd);
            checkValue("dataM.ctl", expM.ctl, dataM.ctl);
            checkValue("dataM.newMstatus", expM.newMstatus, dataM.newMstatus);
            checkValue("dataM.newPrivilegeMode", expM.newPrivilegeMode,
                       dataM.newPrivilegeMode);
            checkValue("dataM.misaligned", expM.misaligned, dataM.misaligned);
            checkValue("dataM.mcause", expM.mcause, dataM.mcause);
            checkValue("dataM", expM, dataM);
        end
    end

endmodule

//--- exStage.sv
`timescale 1ns/1ps

module exStage (
    input  logic                   clk,
    input  logic                   arstN,
    input  pipesPkg::decodeData_t  dataD,
    input  pipesPkg::fwdData_t     fwdA,
    input  pipesPkg::fwdData_t     fwdB,
    input  logic                   stall,
    input  logic                   flush,
    output pipesPkg::executeData_t dataM,
    output commonPkg::u1           branchEnable,
    output commonPkg::word_t       branchTarget
);
    import pipesPkg::*;

    executeData_t dataE;  // combinational stage result

    execute execute_i (
        .dataD(dataD),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .dataE(dataE),
        .branchEnable(branchEnable),
        .branchTarget(branchTarget)
    );

    exMemReg exMemReg_i (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .flush(flush),
        .dataE(dataE),
        .dataM(dataM)
    );

endmodule

//--- exMemReg.sv
`timescale 1ns/1ps

module exMemReg (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   stall,
    input  logic                   flush,
    input  pipesPkg::executeData_t dataE,
    output pipesPkg::executeData_t dataM
);
    import pipesPkg::*;

    localparam executeData_t emptyEntry = '0;  // invalid, no control bits

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dataM <= emptyEntry;
        end else if (flush) begin
            dataM <= emptyEntry;  // wins over stall
        end else if (!stall) begin
            dataM <= dataE;
        end
    end

endmodule

//--- execute.sv
`timescale 1ns/1ps

module execute (
    input  pipesPkg::decodeData_t  dataD,
    input  pipesPkg::fwdData_t     fwdA,
    input  pipesPkg::fwdData_t     fwdB,
    output pipesPkg::executeData_t dataE,
    output commonPkg::u1           branchEnable,
    output commonPkg::word_t       branchTarget
);
    import commonPkg::*;
    import pipesPkg::*;

    control_t     ctl;
    word_t        srcAReg;
    word_t        srcBReg;
    word_t        src1;
    word_t        src2;
    word_t        aluResult;
    u1            misaligned;
    mstatusWord_t newMstatus;
    u2            newPrivilegeMode;

    assign ctl     = dataD.ctl;
    assign srcAReg = fwdA.enable ? fwdA.data : dataD.srca; // bypass
    assign srcBReg = fwdB.enable ? fwdB.data : dataD.srcb;

    always_comb begin
        if (ctl.pcSrc) begin
            src1 = dataD.pc;       // auipc, jal
        end else if (ctl.csrSrc) begin
            src1 = dataD.csrData;
        end else begin
            src1 = srcAReg;
        end
    end

    assign src2 = ctl.immSrc ? dataD.imm : srcBReg;

    alu alu_i (
        .aluFunc(ctl.aluFunc),
        .src1(src1),
        .src2(src2),
        .aluExt(ctl.aluExt),
        .aluOut(aluResult)
    );

    branchUnit branchUnit_i (
        .branchFunc(ctl.branchFunc),
        .src1(srcAReg),
        .src2(srcBReg),
        .ctl(ctl),
        .pc(dataD.pc),
        .aluOut(aluResult),
        .csrData(dataD.csrData),
        .branchEnable(branchEnable),
        .branchTarget(branchTarget)
    );

    trapUnit trapUnit_i (
        .ctl(ctl),
        .privilegeMode(dataD.privilegeMode),
        .oldMstatus(dataD.extraMstatus),
        .newMstatus(newMstatus),
        .newPrivilegeMode(newPrivilegeMode)
    );

    always_comb begin
        misaligned = 1'b0;
        if (ctl.memRead || ctl.memWrite) begin
            case (ctl.memSize)
                size2:   misaligned = aluResult[0];
                size4:   misaligned = |aluResult[1:0];
                size8:   misaligned = |aluResult[2:0];
                default: misaligned = 1'b0;  // bytes always aligned
            endcase
        end
    end

    always_comb begin
        dataE.valid    = dataD.valid;
        dataE.pc       = dataD.pc;
        dataE.rawInstr = dataD.valid ? dataD.rawInstr : '0;
        dataE.aluOut   = (ctl.jal || ctl.jalr) ? dataD.pc + 64'd4 : aluResult; // link
        dataE.memWd    = srcBReg;
        dataE.csrData  = dataD.csrData;
        dataE.csrAddr  = dataD.csrAddr;
        dataE.ra1      = dataD.ra1;
        dataE.ra2      = dataD.ra2;
        dataE.dst      = dataD.dst;
        dataE.ctl      = ctl;
        if (!dataD.valid) begin
            dataE.ctl = '0;   // bubble carries no side effects
        end
        dataE.newMstatus       = newMstatus;
        dataE.privilegeMode    = dataD.privilegeMode;
        dataE.newPrivilegeMode = newPrivilegeMode;
        dataE.misaligned       = misaligned;
        if (ctl.memWrite) begin
            dataE.mcause = 64'd6;  // store address misaligned
        end else if (ctl.memRead) begin
            dataE.mcause = 64'd4;  // load address misaligned
        end else begin
            dataE.mcause = '0;
        end
    end

endmodule

//--- trapUnit.sv
`timescale 1ns/1ps

module trapUnit (
    input  pipesPkg::control_t      ctl,
    input  commonPkg::u2            privilegeMode,
    input  commonPkg::mstatusWord_t oldMstatus,
    output commonPkg::mstatusWord_t newMstatus,
    output commonPkg::u2            newPrivilegeMode
);
    import commonPkg::*;
    import pipesPkg::*;

    always_comb begin
        newMstatus.raw   = oldMstatus.raw;
        newPrivilegeMode = privilegeMode;
        if (ctl.exception) begin
            // trap entry into machine mode
            newMstatus.fields.mpp  = privilegeMode;
            newMstatus.fields.mpie = oldMstatus.fields.mie;
            newMstatus.fields.mie  = 1'b0;   // interrupts off in handler
            newPrivilegeMode       = privMachine;
        end else if (ctl.mret) begin
            newMstatus.fields.mie  = oldMstatus.fields.mpie;
            newMstatus.fields.mpie = 1'b1;
            newMstatus.fields.mpp  = privUser;
            newMstatus.fields.xs   = 2'b00;
            newPrivilegeMode       = privUser; // back to user
        end
    end

endmodule

//--- branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
    input  pipesPkg::branchFunc_t branchFunc,
    input  commonPkg::word_t      src1,
    input  commonPkg::word_t      src2,
    input  pipesPkg::control_t    ctl,
    input  commonPkg::word_t      pc,
    input  commonPkg::word_t      aluOut,
    input  commonPkg::word_t      csrData,
    output commonPkg::u1          branchEnable,
    output commonPkg::word_t      branchTarget
);
    import commonPkg::*;
    import pipesPkg::*;

    u1     taken;
    word_t pcPlus4;
    word_t target;

    always_comb begin
        case (branchFunc)
            brEq:     taken = (src1 == src2);
            brNe:     taken = (src1 != src2);
            brLt:     taken = ($signed(src1) < $signed(src2));
            brGe:     taken = ($signed(src1) >= $signed(src2));
            brLtu:    taken = (src1 < src2);
            brGeu:    taken = (src1 >= src2);
            brAlways: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + 64'd4;
    assign branchEnable = taken | ctl.jal | ctl.jalr | ctl.mret | ctl.exception | ctl.csrSrc;

    always_comb begin
        if (ctl.exception || ctl.mret) begin
            target = csrData;                 // trap vector or mepc
        end else if (ctl.csrSrc) begin
            target = pcPlus4;                 // refetch after csr write
        end else if (ctl.jalr) begin
            target = {aluOut[63:1], 1'b0};
        end else begin
            target = aluOut;
        end
    end

    assign branchTarget = branchEnable ? target : '0;

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  pipesPkg::aluFunc_t aluFunc,
    input  commonPkg::word_t   src1,
    input  commonPkg::word_t   src2,
    input  commonPkg::u1       aluExt,
    output commonPkg::word_t   aluOut
);
    import commonPkg::*;
    import pipesPkg::*;

    word_t      shiftSrc;
    logic [5:0] shamt;
    word_t      result;

    always_comb begin
        shamt    = aluExt ? {1'b0, src2[4:0]} : src2[5:0]; // word shifts use 5 bits
        shiftSrc = src1;
        if (aluExt) begin
            if (aluFunc == aluSra) begin
                shiftSrc = {{32{src1[31]}}, src1[31:0]};
            end else begin
                shiftSrc = {32'b0, src1[31:0]};
            end
        end
    end

    always_comb begin
        case (aluFunc)
            aluAdd:   result = src1 + src2;
            aluSub:   result = src1 - src2;
            aluAnd:   result = src1 & src2;
            aluOr:    result = src1 | src2;
            aluXor:   result = src1 ^ src2;
            aluSll:   result = shiftSrc << shamt;
            aluSrl:   result = shiftSrc >> shamt;
            aluSra:   result = $signed(shiftSrc) >>> shamt;
            aluSlt:   result = word_t'($signed(src1) < $signed(src2));
            aluSltu:  result = word_t'(src1 < src2);
            aluCopyB: result = src2;
            default:  result = '0;
        endcase
    end

    assign aluOut = aluExt ? {{32{result[31]}}, result[31:0]} : result;

endmodule

//--- pipesPkg.sv
package pipesPkg;
    import commonPkg::*;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu,
        aluCopyB   // lui style pass of src2
    } aluFunc_t;

    typedef enum logic [2:0] {
        brNone,
        brEq,
        brNe,
        brLt,
        brGe,
        brLtu,
        brGeu,
        brAlways
    } branchFunc_t;

    typedef enum logic [1:0] {
        size1,
        size2,
        size4,
        size8
    } memSize_t;

    typedef struct packed {
        aluFunc_t    aluFunc;
        branchFunc_t branchFunc;
        u1           pcSrc;
        u1           csrSrc;
        u1           immSrc;
        u1           aluExt;    // word op, sign-extend low half
        u1           jal;
        u1           jalr;
        u1           mret;
        u1           exception;
        u1           memRead;
        u1           memWrite;
        memSize_t    memSize;
    } control_t;

    typedef struct packed {
        u1     enable;
        word_t data;
    } fwdData_t;

    typedef struct packed {
        u1            valid;
        word_t        pc;
        u32           rawInstr;
        word_t        srca;
        word_t        srcb;
        word_t        imm;
        word_t        csrData;
        u12           csrAddr;
        u5            ra1;
        u5            ra2;
        u5            dst;
        control_t     ctl;
        u2            privilegeMode;
        mstatusWord_t extraMstatus;
    } decodeData_t;

    typedef struct packed {
        u1            valid;
        word_t        pc;
        u32           rawInstr;
        word_t        aluOut;
        word_t        memWd;
        word_t        csrData;
        u12           csrAddr;
        u5            ra1;
        u5            ra2;
        u5            dst;
        control_t     ctl;
        mstatusWord_t newMstatus;
        u2            privilegeMode;
        u2            newPrivilegeMode;
        u1            misaligned;
        word_t        mcause;
    } executeData_t;

endpackage

//--- commonPkg.sv
package commonPkg;

    typedef logic [63:0] word_t;
    typedef logic        u1;
    typedef logic [1:0]  u2;
    typedef logic [4:0]  u5;
    typedef logic [11:0] u12;
    typedef logic [31:0] u32;

    localparam u2 privUser    = 2'b00;
    localparam u2 privMachine = 2'b11;

    // RV64 mstatus, msb first
    typedef struct packed {
        u1           sd;
        logic [26:0] wpri4;
        u2           sxl;
        u2           uxl;
        logic [8:0]  wpri3;
        u1           tsr;
        u1           tw;
        u1           tvm;
        u1           mxr;
        u1           sum;
        u1           mprv;
        u2           xs;
        u2           fs;
        u2           mpp;
        u2           wpri2;
        u1           spp;
        u1           mpie;
        u1           wpri1;
        u1           spie;
        u1           upie;
        u1           mie;
        u1           wpri0;
        u1           sie;
        u1           uie;
    } mstatus_t;

    typedef union packed {
        word_t    raw;    // as stored in the CSR file
        mstatus_t fields; // as edited on trap entry and return
    } mstatusWord_t;

endpackage
